/* rtl/array_mult8.sv */
`timescale 1ns/1ps

module array_mult8 import mul_pkg::*; (
  input  logic       clk,
  input  byte_pair_t pair,
  output pp_word_t   pp
);

  half_t a_op;
  half_t b_op;

  // Row sums and carries of the adder array
  logic [HALF_W-1:0] s_row [HALF_W];
  logic [HALF_W-2:0] c_row [1:HALF_W-1];

  // Final ripple stage
  logic [HALF_W-1:0] rc;
  logic [HALF_W-1:0] hi_sum;
  logic [HALF_W-1:0] lo_bits;

  assign a_op = pair.a_half;
  assign b_op = pair.b_half;

  // Row 0 is plain AND terms
  for (genvar j = 0; j < HALF_W; j++) begin : g_row0
    assign s_row[0][j] = a_op[0] & b_op[j];
  end

  for (genvar i = 1; i < HALF_W; i++) begin : g_rows
    for (genvar j = 0; j < HALF_W - 1; j++) begin : g_cells
      logic pbit;
      logic s_in;

      assign pbit = a_op[i] & b_op[j];
      assign s_in = s_row[i-1][j+1];

      if (i == 1) begin : g_ha
        // No carries yet, half adders suffice
        assign s_row[i][j] = s_in ^ pbit;
        assign c_row[i][j] = s_in & pbit;
      end else begin : g_fa
        assign s_row[i][j] = s_in ^ c_row[i-1][j] ^ pbit;
        assign c_row[i][j] = (s_in & c_row[i-1][j]) |
                             (s_in & pbit) |
                             (c_row[i-1][j] & pbit);
      end
    end

    // Leftmost cell of each row has nothing to add
    assign s_row[i][HALF_W-1] = a_op[i] & b_op[HALF_W-1];
  end

  // Lowest bit of every row is final
  for (genvar i = 0; i < HALF_W; i++) begin : g_lo
    assign lo_bits[i] = s_row[i][0];
  end

  // Ripple the last carries into the remaining sums
  assign rc[0] = 1'b0;

  for (genvar j = 0; j < HALF_W - 1; j++) begin : g_ripple
    logic x;
    logic y;

    assign x = c_row[HALF_W-1][j];
    assign y = s_row[HALF_W-1][j+1];
    assign hi_sum[j] = x ^ y ^ rc[j];
    assign rc[j+1] = (x & y) | (x & rc[j]) | (y & rc[j]);
  end

  assign hi_sum[HALF_W-1] = rc[HALF_W-1];

  always_ff @(posedge clk) begin
    pp.product <= {hi_sum, lo_bits};
    pp.shift <= pair.shift;
  end

endmodule

/* rtl/cla_adder.sv */
`timescale 1ns/1ps

module cla_adder import mul_pkg::*; #(
  parameter int WIDTH = PROD_W
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);

  localparam int NUM_GRP = WIDTH / GROUP_W;

  logic [WIDTH-1:0]   p;
  logic [WIDTH-1:0]   g;
  logic [NUM_GRP-1:0] grp_p;
  logic [NUM_GRP-1:0] grp_g;
  logic [NUM_GRP-1:0] grp_c;

  assign p = a ^ b;
  assign g = a & b;

  // Second level: carry into each group from all lower groups at once
  always_comb begin
    logic term;

    for (int k = 0; k < NUM_GRP; k++) begin
      term = 1'b0;
      grp_c[k] = 1'b0;

      for (int m = 0; m < k; m++) begin
        term = grp_g[m];
        for (int n = m + 1; n < k; n++) begin
          term = term & grp_p[n];
        end
        grp_c[k] = grp_c[k] | term;
      end
    end
  end

  for (genvar k = 0; k < NUM_GRP; k++) begin : g_group
    localparam int B = k * GROUP_W;

    logic [GROUP_W-1:0] c;

    assign grp_p[k] = &p[B +: GROUP_W];
    assign grp_g[k] = g[B+3] |
                      (p[B+3] & g[B+2]) |
                      (p[B+3] & p[B+2] & g[B+1]) |
                      (p[B+3] & p[B+2] & p[B+1] & g[B]);

    // Carries inside the group
    assign c[0] = grp_c[k];
    assign c[1] = g[B] | (p[B] & c[0]);
    assign c[2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & c[0]);
    assign c[3] = g[B+2] | (p[B+2] & g[B+1]) |
                  (p[B+2] & p[B+1] & g[B]) |
                  (p[B+2] & p[B+1] & p[B] & c[0]);

    assign sum[B +: GROUP_W] = p[B +: GROUP_W] ^ c;
  end

endmodule

/* rtl/mul16_top.sv */
`timescale 1ns/1ps

module mul16_top import mul_pkg::*; #(
  parameter int WIDTH = PROD_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [OPER_W-1:0] a,
  input  logic [OPER_W-1:0] b,
  output logic              out_valid,
  output prod_t             product
);

  byte_pair_t pairs [NUM_PP];
  pp_word_t   pps [NUM_PP];
  logic       pair_valid;
  logic       pp_valid;

  operand_splitter u_splitter (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .a          (a),
    .b          (b),
    .pairs      (pairs),
    .pair_valid (pair_valid)
  );

  for (genvar i = 0; i < NUM_PP; i++) begin : g_mult
    array_mult8 u_mult (
      .clk  (clk),
      .pair (pairs[i]),
      .pp   (pps[i])
    );
  end

  // All multipliers share one stage, one strobe follows them
  always_ff @(posedge clk) begin
    if (rst) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= pair_valid;
    end
  end

  product_accumulator #(
    .WIDTH (WIDTH)
  ) u_accum (
    .clk       (clk),
    .rst       (rst),
    .pps       (pps),
    .pp_valid  (pp_valid),
    .product   (product),
    .out_valid (out_valid)
  );

endmodule

/* rtl/mul_pkg.sv */
package mul_pkg;

  // Operand and product geometry
  localparam int HALF_W = 8;
  localparam int OPER_W = 2 * HALF_W;
  localparam int PROD_W = 2 * OPER_W;

  // Four byte-by-byte partial products
  localparam int NUM_PP = 4;

  // Lookahead group size of the adders
  localparam int GROUP_W = 4;

  // Splitter, multiplier and accumulator stages
  localparam int PIPE_LAT = 3;

  typedef logic [HALF_W-1:0] half_t;
  typedef logic [2*HALF_W-1:0] pp_t;
  typedef logic [PROD_W-1:0] prod_t;

  // One byte of each operand plus its byte offset in the product
  typedef struct packed {
    half_t a_half;
    half_t b_half;
    logic [1:0] shift;
  } byte_pair_t;

  // Partial product, still carrying its byte offset
  typedef struct packed {
    pp_t product;
    logic [1:0] shift;
  } pp_word_t;

endpackage

/* rtl/operand_splitter.sv */
`timescale 1ns/1ps

module operand_splitter import mul_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  logic [OPER_W-1:0]   a,
  input  logic [OPER_W-1:0]   b,
  output byte_pair_t          pairs [NUM_PP],
  output logic                pair_valid
);

  logic [OPER_W-1:0] a_q;
  logic [OPER_W-1:0] b_q;
  half_t a_lo;
  half_t a_hi;
  half_t b_lo;
  half_t b_hi;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_q <= a;
      b_q <= b;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= in_valid;
    end
  end

  assign a_lo = a_q[HALF_W-1:0];
  assign a_hi = a_q[OPER_W-1:HALF_W];
  assign b_lo = b_q[HALF_W-1:0];
  assign b_hi = b_q[OPER_W-1:HALF_W];

  // Byte offsets: lo*lo at 0, cross terms at 1, hi*hi at 2
  assign pairs[0] = '{a_half: a_lo, b_half: b_lo, shift: 2'd0};
  assign pairs[1] = '{a_half: a_hi, b_half: b_lo, shift: 2'd1};
  assign pairs[2] = '{a_half: a_lo, b_half: b_hi, shift: 2'd1};
  assign pairs[3] = '{a_half: a_hi, b_half: b_hi, shift: 2'd2};

endmodule

/* rtl/product_accumulator.sv */
`timescale 1ns/1ps

module product_accumulator import mul_pkg::*; #(
  parameter int WIDTH = PROD_W
) (
  input  logic     clk,
  input  logic     rst,
  input  pp_word_t pps [NUM_PP],
  input  logic     pp_valid,
  output prod_t    product,
  output logic     out_valid
);

  localparam int PP_W = $bits(pp_t);

  logic [WIDTH-1:0] aligned [NUM_PP];
  logic [WIDTH-1:0] outer_word;
  logic [WIDTH-1:0] first_sum;
  logic [WIDTH-1:0] total_sum;

  // Place each partial product at its byte offset
  for (genvar i = 0; i < NUM_PP; i++) begin : g_align
    assign aligned[i] = {{(WIDTH-PP_W){1'b0}}, pps[i].product} << (pps[i].shift * HALF_W);
  end

  // lo*lo and hi*hi never overlap, so this is just {hh, ll}
  assign outer_word = aligned[0] | aligned[NUM_PP-1];

  cla_adder #(
    .WIDTH (WIDTH)
  ) u_add_first (
    .a   (outer_word),
    .b   (aligned[1]),
    .sum (first_sum)
  );

  cla_adder #(
    .WIDTH (WIDTH)
  ) u_add_second (
    .a   (first_sum),
    .b   (aligned[2]),
    .sum (total_sum)
  );

  always_ff @(posedge clk) begin
    product <= total_sum;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pp_valid;
    end
  end

endmodule

/* verification/mul16_chk.sv */
`timescale 1ns/1ps

module mul16_chk import mul_pkg::*; (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic out_valid
);

  int fail_count;

  initial begin
    fail_count = 0;
  end

  // Output stays quiet through reset and the first cycle after it
  reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high during reset or in the cycle after it");
    end

  // Each accepted input yields a result PIPE_LAT cycles later
  latency_fwd: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> ##PIPE_LAT out_valid)
    else begin
      fail_count++;
      $error("out_valid missing %0d cycles after in_valid", PIPE_LAT);
    end

  // No result without an input PIPE_LAT cycles earlier
  latency_back: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> $past(in_valid, PIPE_LAT))
    else begin
      fail_count++;
      $error("out_valid without an input %0d cycles earlier", PIPE_LAT);
    end

endmodule

bind mul16_top mul16_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid)
);

/* verification/mul16_monitor.sv */
`timescale 1ns/1ps

module mul16_monitor import mul_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [OPER_W-1:0] a,
  input  logic [OPER_W-1:0] b,
  input  prod_t             exp_product,
  input  logic              out_valid,
  input  prod_t             product,
  output int                error_count,
  output int                done_count
);

  // One accepted input waiting for its result
  typedef struct packed {
    logic [OPER_W-1:0] a;
    logic [OPER_W-1:0] b;
    prod_t             predicted;
    prod_t             expected;
    logic [31:0]       issued;
  } pending_t;

  pending_t    pend_q [$];
  logic [31:0] cycle_no;

  initial begin
    error_count = 0;
    done_count = 0;
    cycle_no = '0;
  end

  task automatic check_result(input pending_t item);
    logic        ok;
    logic [31:0] latency;
    ok = 1'b1;
    latency = cycle_no - item.issued;
    if (product !== item.predicted || product !== item.expected) begin
      ok = 1'b0;
      $display("error at %0t: product %h, predicted %h, table value %h",
               $time, product, item.predicted, item.expected);
    end
    if (latency != PIPE_LAT) begin
      ok = 1'b0;
      $display("Result of test %0d arrived after %0d cycles instead of %0d",
               done_count, latency, PIPE_LAT);
    end
    if (!ok) begin
      error_count++;
    end
    $display("test %0d: a=%h b=%h product=%h %s", done_count, item.a, item.b, product,
             ok ? "pass" : "fail");
    done_count++;
  endtask

  task automatic print_counts();
    $display("Checked %0d results, %0d with errors, %0d still pending",
             done_count, error_count, pend_q.size());
  endtask

  always @(posedge clk) begin : sample
    pending_t item;
    cycle_no = cycle_no + 1;
    if (!rst && out_valid) begin
      if (pend_q.size() == 0) begin
        error_count++;
        $display("Extra out_valid pulse at %0t with no input in flight", $time);
      end else begin
        check_result(pend_q.pop_front());
      end
    end
    if (!rst && in_valid) begin
      item.a = a;
      item.b = b;
      item.predicted = prod_t'(a) * prod_t'(b);
      item.expected = exp_product;
      item.issued = cycle_no;
      pend_q.push_back(item);
    end
  end

endmodule

/* verification/mul16_tb.sv */
`timescale 1ns/1ps

module mul16_tb import mul_pkg::*; ();

  localparam int NUM_CORNER = 8;
  localparam int NUM_B2B = 24;
  localparam int NUM_GAPPED = 24;
  localparam int NUM_ROWS = NUM_CORNER + NUM_B2B + NUM_GAPPED;

  typedef struct packed {
    logic [OPER_W-1:0] a;
    logic [OPER_W-1:0] b;
    logic [3:0]        gap;
    prod_t             expected;
  } row_t;

  logic              clk;
  logic              rst;
  logic              in_valid;
  logic [OPER_W-1:0] a;
  logic [OPER_W-1:0] b;
  logic              out_valid;
  prod_t             product;
  prod_t             exp_product;

  int mon_errors;
  int mon_done;

  row_t        table_rows [NUM_ROWS];
  logic [15:0] lfsr_state;
  int          cycle_count;
  int          cycle_limit;

  mul16_top #(
    .WIDTH (PROD_W)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  mul16_monitor u_mon (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .a           (a),
    .b           (b),
    .exp_product (exp_product),
    .out_valid   (out_valid),
    .product     (product),
    .error_count (mon_errors),
    .done_count  (mon_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[15]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic build_table();
    logic [15:0] ra;
    logic [15:0] rb;
    logic [15:0] rg;
    int          slots;
    table_rows[0] = '{a: 16'h0000, b: 16'h0000, gap: 4'd1, expected: 32'h0000_0000};
    table_rows[1] = '{a: 16'h0001, b: 16'h0001, gap: 4'd0, expected: 32'h0000_0001};
    table_rows[2] = '{a: 16'h0000, b: 16'hFFFF, gap: 4'd0, expected: 32'h0000_0000};
    table_rows[3] = '{a: 16'h0001, b: 16'hABCD, gap: 4'd2, expected: 32'h0000_ABCD};
    table_rows[4] = '{a: 16'hFFFF, b: 16'hFFFF, gap: 4'd0, expected: 32'hFFFE_0001};
    table_rows[5] = '{a: 16'h00FF, b: 16'hFF00, gap: 4'd1, expected: 32'h00FE_0100};
    table_rows[6] = '{a: 16'h8000, b: 16'h0002, gap: 4'd0, expected: 32'h0001_0000};
    table_rows[7] = '{a: 16'hFFFF, b: 16'h0001, gap: 4'd3, expected: 32'h0000_FFFF};
    for (int i = NUM_CORNER; i < NUM_ROWS; i++) begin
      draw_bits(OPER_W, ra);
      draw_bits(OPER_W, rb);
      rg = '0;
      // Back-to-back block first, then random gaps of 0 to 3
      if (i >= NUM_CORNER + NUM_B2B) begin
        draw_bits(2, rg);
      end
      table_rows[i] = '{a: ra, b: rb, gap: rg[3:0], expected: prod_t'(ra) * prod_t'(rb)};
    end
    slots = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      slots = slots + 1 + table_rows[i].gap;
    end
    cycle_limit = 2 * slots + 20;
  endtask

  task automatic apply_row(input row_t r);
    @(negedge clk);
    in_valid = 1'b1;
    a = r.a;
    b = r.b;
    exp_product = r.expected;
    repeat (r.gap) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: results still missing after %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    a = '0;
    b = '0;
    exp_product = '0;
    lfsr_state = 16'd2;
    cycle_count = 0;
    cycle_limit = 0;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(table_rows[i]);
    end
    @(negedge clk);
    in_valid = 1'b0;
    wait (mon_done == NUM_ROWS);
    // Extra cycles to catch stray out_valid pulses
    repeat (PIPE_LAT + 2) @(posedge clk);
    u_mon.print_counts();
    if (mon_errors == 0 && mon_done == NUM_ROWS && UUT.u_chk.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
rtl/mul_pkg.sv
rtl/operand_splitter.sv
rtl/array_mult8.sv
rtl/cla_adder.sv
rtl/product_accumulator.sv
rtl/mul16_top.sv
verification/mul16_chk.sv
verification/mul16_monitor.sv
verification/mul16_tb.sv
